// File: Bender.yml
package:
  name: rcc_sequencer

sources:
  - include_dirs:
      - source
    files:
      - source/rcc_pkg.sv
      - source/rcc_seq_if.sv
      - source/rcc_cmd_capture.sv
      - source/rcc_sequencer.sv
      - source/rcc_output_stage.sv
      - source/rcc_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - testbench/rcc_clock_gen.sv
      - testbench/rcc_checker.sv
      - testbench/rcc_sva.sv
      - testbench/rcc_tb.sv

// File: build.f
+incdir+source
source/rcc_pkg.sv
source/rcc_seq_if.sv
source/rcc_cmd_capture.sv
source/rcc_sequencer.sv
source/rcc_output_stage.sv
source/rcc_top.sv
testbench/rcc_clock_gen.sv
testbench/rcc_checker.sv
testbench/rcc_sva.sv
testbench/rcc_tb.sv

// File: source/rcc_cmd_capture.sv
// RCC command capture
// Syncs the hardware reset request and loads target mode and force bit
// from the register-file strobe, one cycle after the strobe

`timescale 1ns/1ns

`include "rcc_config.svh"

module rcc_cmd_capture
  import rcc_pkg::*;
(
  input  logic                  rcg_ctrl_rf_clk,
  input  logic                  rcc_async_reset_n,
  input  logic                  rf_stb,
  input  logic [`RCC_CMD_W-1:0] rf_state_in,
  input  logic                  force_enable,
  input  rcc_mode_e             init_state,
  input  logic                  hw_rst_req,
  output rcc_mode_e             target,
  output logic                  clk_en_force,
  output logic                  hw_rst
);

  logic hw_rst_s1;
  logic stb_d;

  // ------------------------------
  // Hardware reset request sync
  // ------------------------------
  always_ff @(posedge rcg_ctrl_rf_clk or negedge rcc_async_reset_n)
  begin
    if (!rcc_async_reset_n)
    begin
      hw_rst_s1 <= 1'b0;
      hw_rst    <= 1'b0;
    end
    else
    begin
      hw_rst_s1 <= hw_rst_req;
      hw_rst    <= hw_rst_s1;
    end
  end

  // ------------------------------
  // Command load
  // ------------------------------
  // Data is stable one cycle after the strobe
  always_ff @(posedge rcg_ctrl_rf_clk or negedge rcc_async_reset_n)
  begin
    if (!rcc_async_reset_n)
    begin
      stb_d        <= 1'b0;
      target       <= init_state;
      clk_en_force <= 1'b0;
    end
    else
    begin
      stb_d <= rf_stb;
      // Priority: hw reset, force enable, strobe
      if (hw_rst)
        target <= init_state;
      else if (force_enable)
        target <= ENABLE;
      else if (stb_d)
        target <= rcc_mode_e'(rf_state_in[1:0]);
      // Force bit from top command bit
      if (stb_d)
        clk_en_force <= rf_state_in[`RCC_CMD_W-1];
    end
  end

endmodule

// File: source/rcc_config.svh
// RCC sequencer configuration
// Phase lengths and word widths shared by the design and its checks

`ifndef RCC_CONFIG_SVH
`define RCC_CONFIG_SVH

// ------------------------------
// Phase lengths
// ------------------------------
// Last SYNC_RST count value, phase is one longer
`define RCC_SYNC_RST_PERIOD 31
// Last CLK_DIS count with reset held and clock off
`define RCC_CLK_DIS_PERIOD 31
// CLK_DIS cycles with reset released
`define RCC_CLK_DIS_RELEASE 40

// ------------------------------
// Widths
// ------------------------------
`define RCC_CNT_W 8
`define RCC_STATUS_W 6
`define RCC_CMD_W 3

`endif

// File: source/rcc_output_stage.sv
// RCC output stage
// Merges the force bit into reset and clock gate, registers the module
// controls and packs the status word for the register file

`timescale 1ns/1ns

`include "rcc_config.svh"

module rcc_output_stage
  import rcc_pkg::*;
(
  input  logic                     rcg_ctrl_rf_clk,
  input  logic                     rcc_async_reset_n,
  rcc_seq_if.out                   seq,
  input  rcc_mode_e                target,
  input  logic                     clk_en_force,
  output logic                     mod_rst_out_n,
  output logic                     mod_gclk_cg_en,
  output logic                     mod_disable,
  output logic [`RCC_STATUS_W-1:0] rf_state_out
);

  logic        rst_n_d;
  logic        cg_en_d;
  rcc_status_t status_q;

  // Force bit holds the module out of reset with its clock on
  assign rst_n_d = seq.mod_rst_n | clk_en_force;
  assign cg_en_d = seq.mod_cg_enable | clk_en_force;

  always_ff @(posedge rcg_ctrl_rf_clk or negedge rcc_async_reset_n)
  begin
    if (!rcc_async_reset_n)
    begin
      mod_rst_out_n  <= 1'b0;
      mod_gclk_cg_en <= 1'b0;
      mod_disable    <= 1'b1;
      status_q       <= '0;
    end
    else
    begin
      mod_rst_out_n  <= rst_n_d;
      mod_gclk_cg_en <= cg_en_d;
      mod_disable    <= seq.mod_disable;
      // Status mirrors the outputs of this same edge
      status_q.cg_en  <= cg_en_d;
      status_q.rst_n  <= rst_n_d;
      status_q.target <= target;
      status_q.state  <= seq.state;
    end
  end

  assign rf_state_out = status_q;

endmodule

// File: source/rcc_pkg.sv
// RCC shared types
// Mode encoding and status word layout

package rcc_pkg;

  // Target mode and sequencer state share one encoding
  typedef enum logic [1:0]
  {
    DISABLE  = 2'b00,
    SYNC_RST = 2'b01,
    CLK_DIS  = 2'b10,
    ENABLE   = 2'b11
  } rcc_mode_e;

  // Status word, MSB first
  typedef struct packed
  {
    logic      cg_en;
    logic      rst_n;
    rcc_mode_e target;
    rcc_mode_e state;
  } rcc_status_t;

endpackage

// File: source/rcc_seq_if.sv
// RCC sequencer to output stage link
// Carries FSM state and the raw reset, clock gate and disable controls

`timescale 1ns/1ns

interface rcc_seq_if
  import rcc_pkg::*;
();

  // Current FSM state
  rcc_mode_e state;
  // Module reset, active low
  logic      mod_rst_n;
  // Clock gate enable before force
  logic      mod_cg_enable;
  // Module disabled flag
  logic      mod_disable;

  modport seq
  (
    output state,
    output mod_rst_n,
    output mod_cg_enable,
    output mod_disable
  );

  modport out
  (
    input state,
    input mod_rst_n,
    input mod_cg_enable,
    input mod_disable
  );

endinterface

// File: source/rcc_sequencer.sv
// RCC mode sequencer
// Walks the module through reset and clock gate phases toward the target
// mode, negotiating a req/ack disable before leaving ENABLE

`timescale 1ns/1ns

`include "rcc_config.svh"

module rcc_sequencer
  import rcc_pkg::*;
(
  input  logic      rcg_ctrl_rf_clk,
  input  logic      rcc_async_reset_n,
  input  rcc_mode_e target,
  input  logic      hw_rst,
  input  logic      clk_en_force,
  input  logic      disable_ack,
  output logic      disable_req,
  rcc_seq_if.seq    seq
);

  localparam logic [`RCC_CNT_W-1:0] SYNC_LAST = `RCC_SYNC_RST_PERIOD;
  localparam logic [`RCC_CNT_W-1:0] DIS_LAST  = `RCC_CLK_DIS_PERIOD;
  localparam logic [`RCC_CNT_W-1:0] REL_LAST  = `RCC_CLK_DIS_PERIOD + `RCC_CLK_DIS_RELEASE;

  rcc_mode_e             state_q, state_d;
  logic                  rst_n_q, rst_n_d;
  logic                  cg_q, cg_d;
  logic                  dis_q, dis_d;
  logic                  req_d;
  logic [`RCC_CNT_W-1:0] sync_cnt_q, sync_cnt_d;
  logic [`RCC_CNT_W-1:0] dis_cnt_q, dis_cnt_d;
  logic                  ack_s1;
  logic                  ack_sync;

  // ------------------------------
  // Ack synchronizer
  // ------------------------------
  always_ff @(posedge rcg_ctrl_rf_clk or negedge rcc_async_reset_n)
  begin
    if (!rcc_async_reset_n)
    begin
      ack_s1   <= 1'b0;
      ack_sync <= 1'b0;
    end
    else
    begin
      ack_s1   <= disable_ack;
      ack_sync <= ack_s1;
    end
  end

  // ------------------------------
  // Next state logic
  // ------------------------------
  always_comb
  begin
    // Hold everything by default
    state_d    = state_q;
    rst_n_d    = rst_n_q;
    cg_d       = cg_q;
    dis_d      = dis_q;
    req_d      = disable_req;
    sync_cnt_d = sync_cnt_q;
    dis_cnt_d  = dis_cnt_q;
    case (state_q)
      DISABLE:
      begin
        sync_cnt_d = '0;
        dis_cnt_d  = '0;
        rst_n_d    = 1'b0;
        cg_d       = 1'b0;
        if (target != DISABLE)
        begin
          state_d = SYNC_RST;
          cg_d    = 1'b1;
        end
      end
      SYNC_RST:
      begin
        // Clock on, reset held
        rst_n_d = 1'b0;
        cg_d    = 1'b1;
        if (target != SYNC_RST)
        begin
          if (sync_cnt_q < SYNC_LAST)
            sync_cnt_d = sync_cnt_q + 1'b1;
          else if (target == DISABLE)
          begin
            state_d    = DISABLE;
            cg_d       = 1'b0;
            sync_cnt_d = '0;
          end
          else
          begin
            // ENABLE goes through CLK_DIS too
            state_d    = CLK_DIS;
            cg_d       = 1'b0;
            sync_cnt_d = '0;
            dis_cnt_d  = '0;
          end
        end
      end
      CLK_DIS:
      begin
        cg_d = 1'b0;
        if (dis_cnt_q < DIS_LAST)
        begin
          rst_n_d   = 1'b0;
          dis_cnt_d = dis_cnt_q + 1'b1;
        end
        else if (dis_cnt_q < REL_LAST)
        begin
          // Reset released, clock still off
          rst_n_d   = 1'b1;
          dis_cnt_d = dis_cnt_q + 1'b1;
        end
        else
        begin
          rst_n_d = 1'b1;
          if (target != CLK_DIS)
            state_d = ENABLE;
        end
      end
      ENABLE:
      begin
        if (disable_req)
        begin
          // Back-pressure: wait here until ack seen
          if (ack_sync)
          begin
            req_d = 1'b0;
            dis_d = 1'b1;
            if (target == CLK_DIS)
            begin
              state_d = CLK_DIS;
              cg_d    = 1'b0;
              rst_n_d = 1'b1;
            end
            else
            begin
              state_d    = SYNC_RST;
              cg_d       = 1'b1;
              rst_n_d    = 1'b0;
              sync_cnt_d = '0;
            end
          end
        end
        else if (target != ENABLE)
        begin
          // New request only once the previous ack is gone
          if (!ack_sync)
            req_d = 1'b1;
        end
        else
        begin
          cg_d    = 1'b1;
          rst_n_d = 1'b1;
          dis_d   = 1'b0;
        end
      end
      default:
      begin
        state_d = DISABLE;
      end
    endcase
  end

  // ------------------------------
  // State registers
  // ------------------------------
  always_ff @(posedge rcg_ctrl_rf_clk or negedge rcc_async_reset_n)
  begin
    if (!rcc_async_reset_n)
    begin
      state_q     <= DISABLE;
      rst_n_q     <= 1'b0;
      cg_q        <= 1'b0;
      dis_q       <= 1'b1;
      disable_req <= 1'b0;
      sync_cnt_q  <= '0;
      dis_cnt_q   <= '0;
    end
    else if (hw_rst)
    begin
      // Hardware request restarts the reset phase
      state_q     <= SYNC_RST;
      rst_n_q     <= 1'b0;
      cg_q        <= 1'b1;
      dis_q       <= 1'b1;
      disable_req <= 1'b0;
      sync_cnt_q  <= '0;
      dis_cnt_q   <= '0;
    end
    else
    begin
      state_q     <= state_d;
      rst_n_q     <= rst_n_d;
      cg_q        <= cg_d;
      dis_q       <= dis_d & ~clk_en_force;
      disable_req <= req_d;
      sync_cnt_q  <= sync_cnt_d;
      dis_cnt_q   <= dis_cnt_d;
    end
  end

  assign seq.state         = state_q;
  assign seq.mod_rst_n     = rst_n_q;
  assign seq.mod_cg_enable = cg_q;
  assign seq.mod_disable   = dis_q;

endmodule

// File: source/rcc_top.sv
// RCC top level
// Command capture, mode sequencer and output stage of one clock-controller
// slice, all on the register-file clock

`timescale 1ns/1ns

`include "rcc_config.svh"

module rcc_top
  import rcc_pkg::*;
(
  input  logic                     rcg_ctrl_rf_clk,
  input  logic                     rcc_async_reset_n,
  // Register-file command and status
  input  logic                     rf_stb,
  input  logic [`RCC_CMD_W-1:0]    rf_state_in,
  output logic [`RCC_STATUS_W-1:0] rf_state_out,
  // Defaults and hardware request
  input  logic                     force_enable,
  input  rcc_mode_e                init_state,
  input  logic                     hw_rst_req,
  // Module controls
  output logic                     mod_rst_out_n,
  output logic                     mod_gclk_cg_en,
  output logic                     mod_disable,
  // Disable handshake
  output logic                     mod_disable_req,
  input  logic                     disable_ack
);

  rcc_mode_e target;
  logic      clk_en_force;
  logic      hw_rst;

  rcc_seq_if seq_if ();

  // ------------------------------
  // Stage one
  // ------------------------------
  rcc_cmd_capture u_cmd_capture
  (
    .rcg_ctrl_rf_clk   (rcg_ctrl_rf_clk),
    .rcc_async_reset_n (rcc_async_reset_n),
    .rf_stb            (rf_stb),
    .rf_state_in       (rf_state_in),
    .force_enable      (force_enable),
    .init_state        (init_state),
    .hw_rst_req        (hw_rst_req),
    .target            (target),
    .clk_en_force      (clk_en_force),
    .hw_rst            (hw_rst)
  );

  // Stage two
  rcc_sequencer u_sequencer
  (
    .rcg_ctrl_rf_clk   (rcg_ctrl_rf_clk),
    .rcc_async_reset_n (rcc_async_reset_n),
    .target            (target),
    .hw_rst            (hw_rst),
    .clk_en_force      (clk_en_force),
    .disable_ack       (disable_ack),
    .disable_req       (mod_disable_req),
    .seq               (seq_if.seq)
  );

  // Stage three
  rcc_output_stage u_output_stage
  (
    .rcg_ctrl_rf_clk   (rcg_ctrl_rf_clk),
    .rcc_async_reset_n (rcc_async_reset_n),
    .seq               (seq_if.out),
    .target            (target),
    .clk_en_force      (clk_en_force),
    .mod_rst_out_n     (mod_rst_out_n),
    .mod_gclk_cg_en    (mod_gclk_cg_en),
    .mod_disable       (mod_disable),
    .rf_state_out      (rf_state_out)
  );

endmodule

// File: testbench/rcc_checker.sv
// RCC scoreboard
// Target mode model, value comparisons, per-test result lines and the summary

`timescale 1ns/1ns

`include "rcc_config.svh"

module rcc_checker
  import rcc_pkg::*;
(
  input logic                     rcg_ctrl_rf_clk,
  input logic                     rcc_async_reset_n,
  input logic                     rf_stb,
  input logic [`RCC_CMD_W-1:0]    rf_state_in,
  input logic                     force_enable,
  input rcc_mode_e                init_state,
  input logic                     hw_rst_req,
  input logic                     mod_rst_out_n,
  input logic                     mod_gclk_cg_en,
  input logic                     mod_disable,
  input logic [`RCC_STATUS_W-1:0] rf_state_out
);

  int unsigned error_count   = 0;
  int unsigned test_count    = 0;
  int unsigned failed_tests  = 0;
  int unsigned errors_before = 0;

  logic        hw_meta;
  logic        hw_sync;
  logic        stb_late;
  logic        force_cmd;
  logic        force_shown;
  rcc_mode_e   target_cmd;
  rcc_mode_e   target_shown;
  rcc_status_t status;

  assign status = rf_state_out;

  // ------------------------------
  // Target and force model
  // ------------------------------
  // Request sync is two flops, data follows the strobe by one edge,
  // status shows the target one edge after it is loaded
  always_ff @(posedge rcg_ctrl_rf_clk or negedge rcc_async_reset_n)
  begin
    if (!rcc_async_reset_n)
    begin
      hw_meta      <= 1'b0;
      hw_sync      <= 1'b0;
      stb_late     <= 1'b0;
      force_cmd    <= 1'b0;
      force_shown  <= 1'b0;
      target_cmd   <= init_state;
      target_shown <= DISABLE;
    end
    else
    begin
      hw_meta  <= hw_rst_req;
      hw_sync  <= hw_meta;
      stb_late <= rf_stb;
      if (hw_sync)
        target_cmd <= init_state;
      else if (force_enable)
        target_cmd <= ENABLE;
      else if (stb_late)
        target_cmd <= rcc_mode_e'(rf_state_in[1:0]);
      if (stb_late)
        force_cmd <= rf_state_in[`RCC_CMD_W-1];
      target_shown <= target_cmd;
      force_shown  <= force_cmd;
    end
  end

  // Every cycle: status target, and forced outputs
  always @(negedge rcg_ctrl_rf_clk)
  begin
    if (rcc_async_reset_n)
    begin
      check_value("status target", status.target, target_shown);
      if (force_shown)
      begin
        check_value("forced mod_rst_out_n", mod_rst_out_n, 1'b1);
        check_value("forced mod_gclk_cg_en", mod_gclk_cg_en, 1'b1);
      end
    end
  end

  // ------------------------------
  // Compare and report
  // ------------------------------
  task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic note_failure(input string what);
    error_count++;
    $display("ERROR at %0t ns: %s", $time, what);
  endtask

  // Module pins and the matching status bits
  task automatic check_outputs(input logic rst_n_exp, input logic cg_exp, input logic dis_exp);
    check_value("mod_rst_out_n", mod_rst_out_n, rst_n_exp);
    check_value("mod_gclk_cg_en", mod_gclk_cg_en, cg_exp);
    check_value("mod_disable", mod_disable, dis_exp);
    check_value("status rst_n", status.rst_n, rst_n_exp);
    check_value("status cg_en", status.cg_en, cg_exp);
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (error_count == errors_before)
      $display("[%0t ns] test %0d %s: PASS", $time, test_count, name);
    else
    begin
      failed_tests++;
      $display("[%0t ns] test %0d %s: FAIL with %0d errors", $time, test_count, name,
               error_count - errors_before);
    end
    errors_before = error_count;
  endtask

  task automatic report_summary(input int unsigned sva_failures);
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors, %0d assertion failures",
             test_count, test_count - failed_tests, failed_tests, error_count, sva_failures);
  endtask

endmodule

// File: testbench/rcc_clock_gen.sv
// RCC testbench clock and reset
// 8 ns register-file clock, active-low reset held for the first 8 cycles

`timescale 1ns/1ns

module rcc_clock_gen
#(
  parameter int HALF_PERIOD  = 4,
  parameter int RESET_CYCLES = 8
)
(
  output logic rcg_ctrl_rf_clk,
  output logic rcc_async_reset_n
);

  initial
  begin
    rcg_ctrl_rf_clk   = 1'b0;
    rcc_async_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge rcg_ctrl_rf_clk);
    // Release on a clock edge
    rcc_async_reset_n <= 1'b1;
  end

  always #HALF_PERIOD rcg_ctrl_rf_clk = ~rcg_ctrl_rf_clk;

endmodule

// File: testbench/rcc_sva.sv
// RCC sequencer assertions
// Disable handshake ordering and legal reset and clock gate combinations

`timescale 1ns/1ns

module rcc_sva
  import rcc_pkg::*;
(
  input logic      rcg_ctrl_rf_clk,
  input logic      rcc_async_reset_n,
  input logic      hw_rst,
  input logic      disable_req,
  input logic      ack_sync,
  input rcc_mode_e state,
  input logic      mod_rst_n,
  input logic      mod_cg_enable
);

  int unsigned fail_count = 0;

  // New request only once the previous ack is gone
  req_rise_ack_low: assert property (@(posedge rcg_ctrl_rf_clk) disable iff (!rcc_async_reset_n)
    $rose(disable_req) |-> !$past(ack_sync))
  else
  begin
    fail_count++;
    $error("disable_req rose while the synchronized ack was high");
  end

  // Request holds until the ack arrives, unless a hardware reset aborts it
  req_hold: assert property (@(posedge rcg_ctrl_rf_clk) disable iff (!rcc_async_reset_n)
    disable_req && !ack_sync && !hw_rst |=> disable_req)
  else
  begin
    fail_count++;
    $error("disable_req dropped before the ack");
  end

  // Clock on with reset released is for ENABLE only
  run_only_enable: assert property (@(posedge rcg_ctrl_rf_clk) disable iff (!rcc_async_reset_n)
    state != ENABLE |-> !(mod_rst_n && mod_cg_enable))
  else
  begin
    fail_count++;
    $error("clock on and reset released outside ENABLE");
  end

endmodule

bind rcc_sequencer rcc_sva u_sva
(
  .rcg_ctrl_rf_clk   (rcg_ctrl_rf_clk),
  .rcc_async_reset_n (rcc_async_reset_n),
  .hw_rst            (hw_rst),
  .disable_req       (disable_req),
  .ack_sync          (ack_sync),
  .state             (state_q),
  .mod_rst_n         (rst_n_q),
  .mod_cg_enable     (cg_q)
);

// File: testbench/rcc_tb.sv
// RCC testbench top
// Drives register-file commands, answers the disable handshake and runs
// the directed and random tests against the scoreboard

`timescale 1ns/1ns

`include "rcc_config.svh"

module rcc_tb
  import rcc_pkg::*;
();

  localparam logic [31:0] SEED            = 32'h07dbcec4;
  localparam int unsigned NUM_RANDOM_CMDS = 12;
  localparam int unsigned CYCLES_PER_CMD  = 200;
  // Random commands plus eight directed ones, with margin
  localparam int unsigned WATCHDOG_CYCLES = (NUM_RANDOM_CMDS + 8) * CYCLES_PER_CMD + 500;
  localparam rcc_mode_e   INIT_MODE       = SYNC_RST;

  logic                     rcg_ctrl_rf_clk;
  logic                     rcc_async_reset_n;
  logic                     rf_stb       = 1'b0;
  logic [`RCC_CMD_W-1:0]    rf_state_in  = '0;
  logic                     force_enable = 1'b0;
  rcc_mode_e                init_state   = INIT_MODE;
  logic                     hw_rst_req   = 1'b0;
  logic                     disable_ack  = 1'b0;
  logic [`RCC_STATUS_W-1:0] rf_state_out;
  logic                     mod_rst_out_n;
  logic                     mod_gclk_cg_en;
  logic                     mod_disable;
  logic                     mod_disable_req;
  rcc_status_t              status;

  assign status = rf_state_out;

  rcc_clock_gen u_clock_gen
  (
    .rcg_ctrl_rf_clk   (rcg_ctrl_rf_clk),
    .rcc_async_reset_n (rcc_async_reset_n)
  );

  rcc_top DUT
  (
    .rcg_ctrl_rf_clk   (rcg_ctrl_rf_clk),
    .rcc_async_reset_n (rcc_async_reset_n),
    .rf_stb            (rf_stb),
    .rf_state_in       (rf_state_in),
    .rf_state_out      (rf_state_out),
    .force_enable      (force_enable),
    .init_state        (init_state),
    .hw_rst_req        (hw_rst_req),
    .mod_rst_out_n     (mod_rst_out_n),
    .mod_gclk_cg_en    (mod_gclk_cg_en),
    .mod_disable       (mod_disable),
    .mod_disable_req   (mod_disable_req),
    .disable_ack       (disable_ack)
  );

  rcc_checker u_checker
  (
    .rcg_ctrl_rf_clk   (rcg_ctrl_rf_clk),
    .rcc_async_reset_n (rcc_async_reset_n),
    .rf_stb            (rf_stb),
    .rf_state_in       (rf_state_in),
    .force_enable      (force_enable),
    .init_state        (init_state),
    .hw_rst_req        (hw_rst_req),
    .mod_rst_out_n     (mod_rst_out_n),
    .mod_gclk_cg_en    (mod_gclk_cg_en),
    .mod_disable       (mod_disable),
    .rf_state_out      (rf_state_out)
  );

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  // Test flow sits at falling edges, drives land on rising edges
  task automatic idle(input int unsigned cycles);
    repeat (cycles) @(negedge rcg_ctrl_rf_clk);
  endtask

  task automatic send_cmd(input logic [`RCC_CMD_W-1:0] cmd);
    @(posedge rcg_ctrl_rf_clk);
    rf_stb      <= 1'b1;
    rf_state_in <= cmd;
    // Data held for the capture edge after the strobe
    @(posedge rcg_ctrl_rf_clk);
    rf_stb <= 1'b0;
    @(negedge rcg_ctrl_rf_clk);
  endtask

  task automatic wait_state(input rcc_mode_e mode, input int unsigned limit);
    int unsigned waited;
    waited = 0;
    do
    begin
      @(negedge rcg_ctrl_rf_clk);
      waited++;
    end
    while (status.state != mode && waited < limit);
    if (status.state != mode)
      u_checker.note_failure($sformatf("state %s not shown within %0d cycles",
                                       mode.name(), limit));
  endtask

  task automatic wait_req(input logic level, input int unsigned limit);
    int unsigned waited;
    waited = 0;
    do
    begin
      @(negedge rcg_ctrl_rf_clk);
      waited++;
    end
    while (mod_disable_req !== level && waited < limit);
    if (mod_disable_req !== level)
      u_checker.note_failure($sformatf("disable_req did not go to %0b within %0d cycles",
                                       level, limit));
  endtask

  // Ack after a random delay, drop it once req is gone
  initial
  begin : ack_responder
    int unsigned delay;
    forever
    begin
      @(negedge rcg_ctrl_rf_clk);
      if (mod_disable_req && !disable_ack)
      begin
        delay = $urandom_range(15, 0);
        repeat (delay) @(negedge rcg_ctrl_rf_clk);
        @(posedge rcg_ctrl_rf_clk);
        disable_ack <= 1'b1;
        do
          @(negedge rcg_ctrl_rf_clk);
        while (mod_disable_req);
        @(posedge rcg_ctrl_rf_clk);
        disable_ack <= 1'b0;
      end
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial
  begin : main_sequence
    logic [31:0] rand_word;
    int unsigned pulse_len;
    int unsigned sva_failures;
    void'($urandom(SEED));
    wait (rcc_async_reset_n === 1'b1);
    idle(2);

    // Reset values, sampled before the FSM leaves DISABLE
    u_checker.check_outputs(1'b0, 1'b0, 1'b1);
    u_checker.check_value("mod_disable_req", mod_disable_req, 1'b0);
    u_checker.check_value("status state", status.state, DISABLE);
    u_checker.check_value("status target", status.target, INIT_MODE);
    u_checker.end_test("reset values");

    // Random commands, target compared every cycle by the scoreboard
    for (int i = 0; i < NUM_RANDOM_CMDS; i++)
    begin
      rand_word = $urandom();
      send_cmd(rand_word[`RCC_CMD_W-1:0]);
      idle($urandom_range(4, 0));
    end
    send_cmd({1'b0, DISABLE});
    @(posedge rcg_ctrl_rf_clk);
    force_enable <= 1'b1;
    @(posedge rcg_ctrl_rf_clk);
    force_enable <= 1'b0;
    idle(2);
    u_checker.check_value("target after force_enable", status.target, ENABLE);
    u_checker.end_test("random commands");

    // Enable path from DISABLE
    send_cmd({1'b0, DISABLE});
    idle(3);
    wait_state(DISABLE, 400);
    send_cmd({1'b0, ENABLE});
    wait_state(SYNC_RST, 8);
    u_checker.check_value("mod_rst_out_n in SYNC_RST", mod_rst_out_n, 1'b0);
    wait_state(CLK_DIS, 40);
    u_checker.check_value("mod_rst_out_n at CLK_DIS entry", mod_rst_out_n, 1'b0);
    u_checker.check_value("mod_gclk_cg_en at CLK_DIS entry", mod_gclk_cg_en, 1'b0);
    wait_state(ENABLE, 80);
    idle(1);
    u_checker.check_outputs(1'b1, 1'b1, 1'b0);
    u_checker.end_test("enable path");

    // Leaving ENABLE through the handshake
    send_cmd({1'b0, DISABLE});
    wait_req(1'b1, 8);
    wait_req(1'b0, 40);
    u_checker.check_value("disable_ack at req fall", disable_ack, 1'b1);
    wait_state(DISABLE, 80);
    u_checker.check_outputs(1'b0, 1'b0, 1'b1);
    u_checker.end_test("disable handshake");

    // Force bit in DISABLE
    send_cmd(3'b100);
    idle(3);
    u_checker.check_outputs(1'b1, 1'b1, 1'b0);
    send_cmd(3'b000);
    idle(2);
    u_checker.end_test("force bit");

    // Hardware reset request out of ENABLE
    send_cmd({1'b0, ENABLE});
    wait_state(ENABLE, 200);
    pulse_len = $urandom_range(6, 3);
    @(posedge rcg_ctrl_rf_clk);
    hw_rst_req <= 1'b1;
    repeat (pulse_len) @(posedge rcg_ctrl_rf_clk);
    hw_rst_req <= 1'b0;
    wait_state(SYNC_RST, 8);
    u_checker.check_value("target after hw reset", status.target, INIT_MODE);
    u_checker.check_outputs(1'b0, 1'b1, 1'b1);
    u_checker.end_test("hardware reset request");

    sva_failures = DUT.u_sequencer.u_sva.fail_count;
    u_checker.report_summary(sva_failures);
    if (u_checker.error_count == 0 && sva_failures == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge rcg_ctrl_rf_clk);
    $display("ERROR: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule
